// ==== vlog.f ====
design/icache_pkg.sv
design/icache_way_store.sv
design/icache_lru.sv
design/icache_ctrl.sv
design/icache_top.sv
tb/icache_sva.sv
tb/icache_checker.sv
tb/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --top-module icache_tb -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vicache_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$log"; then
    echo "simulation reported failures"
    exit 1
fi
if ! grep -q "NO ERRORS" "$log"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

// ==== tb/icache_tb.sv ====
//************************************************
// testbench for the two-way instruction cache
// random fetch stream against an L2 model with random
// latency and grant drops, checked by icache_checker
//************************************************

`timescale 1ns/1ns

module icache_tb
    import icache_pkg::*;
();

    localparam int reset_cycles = 8;
    localparam int n_fetch      = 452;  // all fetches of all tests
    localparam int max_cycles   = n_fetch * 20 + reset_cycles;

    logic                   clk        = 1'b0;
    logic                   rst_n      = 1'b0;
    logic                   fetch_en   = 1'b0;
    ic_addr_t               if_addr    = '0;
    logic                   ic_en      = 1'b1;
    logic                   l2_rdy     = 1'b0;
    line_t                  l2_line    = '0;
    logic [word_w-1:0]      cpu_data;
    logic                   data_rdy;
    logic                   miss_stall;
    logic                   irq;
    logic [line_addr_w-1:0] l2_addr;
    logic                   force_drop = 1'b0;
    int                     wait_cnt   = 0;
    int                     drop_cnt   = 0;
    int                     cycles     = 0;
    int                     checks;
    int                     errors;
    int                     test_checks = 0;
    int                     test_errors = 0;

    icache_top uut (.*);

    icache_checker chk (
        .clk(clk), .rst_n(rst_n), .fetch_en(fetch_en), .if_addr(if_addr),
        .cpu_data(cpu_data), .data_rdy(data_rdy), .miss_stall(miss_stall), .irq(irq),
        .l2_rdy(l2_rdy), .l2_addr(l2_addr), .checks(checks), .errors(errors)
    );

    always #2 clk = ~clk;

    function automatic line_t l2_line_for(logic [line_addr_w-1:0] a);
        line_t l;
        for (int w = 0; w < words_per_line; w++) begin
            l[w] = {a, 2'(w), 2'b11} ^ 32'h3c96_a55a;
        end
        return l;
    endfunction

    // L2 model with random latency and grant drops at the start of a request
    always @(posedge clk) begin
        if (!rst_n) begin
            l2_rdy <= 1'b0;
            ic_en  <= 1'b1;
        end else begin
            l2_rdy <= 1'b0;
            ic_en  <= 1'b1;
            if (miss_stall && !irq) begin  // miss seen in access
                wait_cnt <= 1 + $urandom % 6;
                drop_cnt <= (force_drop || $urandom % 4 == 0) ? 1 + $urandom % 3 : 0;
            end else if (irq && !l2_rdy) begin
                if (drop_cnt != 0) begin
                    ic_en    <= 1'b0;
                    drop_cnt <= drop_cnt - 1;
                end else if (ic_en) begin  // controller is in req_l2 next cycle
                    if (wait_cnt <= 1) begin
                        l2_rdy  <= 1'b1;
                        l2_line <= l2_line_for(l2_addr);
                    end else begin
                        wait_cnt <= wait_cnt - 1;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // present one address and hold it until data_rdy
    task automatic fetch(input logic [tag_w-1:0] t, input logic [index_w-1:0] x,
                         input logic [offset_w-1:0] o);
        fetch_en <= 1'b1;
        if_addr  <= {t, x, o};
        @(posedge clk);
        while (!data_rdy) begin
            @(posedge clk);
        end
    endtask

    task automatic report_test(input string name);
        fetch_en <= 1'b0;
        @(negedge clk);
        $display("test %-24s %0d checks, %0d errors", name, checks - test_checks,
                 errors - test_errors);
        test_checks = checks;
        test_errors = errors;
        @(posedge clk);
    endtask

    initial begin
        void'($urandom(64682));
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < 4; i++) begin
            fetch(20'h00a00 + 20'(i), 8'(i * 16), 2'(i));
        end
        report_test("reset and cold misses");
        for (int i = 0; i < 4; i++) begin
            for (int w = 0; w < words_per_line; w++) begin
                fetch(20'h00a00 + 20'(i), 8'(i * 16), 2'(w));
            end
        end
        report_test("hits on filled lines");
        for (int i = 0; i < 24; i++) begin
            fetch(20'h00b00 + 20'($urandom % 3), 8'h5a, 2'($urandom % 4));
        end
        report_test("replacement in one set");
        force_drop <= 1'b1;
        for (int i = 0; i < 8; i++) begin
            fetch(20'h00c00 + 20'(i), 8'(i), 2'(i));
        end
        force_drop <= 1'b0;
        report_test("L2 grant drop");
        for (int i = 0; i < 400; i++) begin
            if ($urandom % 4 == 0) begin  // idle gap
                fetch_en <= 1'b0;
                @(posedge clk);
            end
            fetch(20'h00d00 + 20'($urandom % 4), 8'h20 + 8'($urandom % 8), 2'($urandom % 4));
        end
        report_test("random stream");
        @(negedge clk);
        $display("total %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== tb/icache_checker.sv ====
//************************************************
// reference model of the two-way cache
// predicts hit or miss and the word of every fetch
// and counts checks and errors for the testbench
//************************************************

`timescale 1ns/1ns

module icache_checker
    import icache_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   fetch_en,
    input  ic_addr_t               if_addr,
    input  logic [word_w-1:0]      cpu_data,
    input  logic                   data_rdy,
    input  logic                   miss_stall,
    input  logic                   irq,
    input  logic                   l2_rdy,
    input  logic [line_addr_w-1:0] l2_addr,
    output int                     checks,
    output int                     errors
);

    logic             mv [2][sets];   // valid bits per way
    logic [tag_w-1:0] mt [2][sets];
    way_sel_t         mlru [sets];
    logic             saw_irq;        // current fetch went to L2
    logic             stall_d;        // miss_stall one cycle back
    logic             first;

    // L2 word pattern for a line address and word number
    function automatic logic [word_w-1:0] l2_word(logic [line_addr_w-1:0] a,
                                                  logic [offset_w-1:0] w);
        return {a, w, 2'b11} ^ 32'h3c96_a55a;
    endfunction

    always @(posedge clk) begin
        logic                   hit;
        way_sel_t               way;
        logic [word_w-1:0]      exp_word;
        logic [line_addr_w-1:0] exp_laddr;
        if (!rst_n) begin
            for (int i = 0; i < sets; i++) begin
                mv[0][i] = 1'b0;
                mv[1][i] = 1'b0;
                mlru[i]  = 1'b0;
            end
            saw_irq = 1'b0;
            stall_d = 1'b0;
            first   = 1'b1;
            checks  = 0;
            errors  = 0;
        end else begin
            exp_laddr = if_addr[addr_w-1:offset_w];  // word address without the offset
            if (first) begin
                checks++;
                if (irq || miss_stall || data_rdy) begin
                    errors++;
                    $display("irq, miss_stall or data_rdy active in first cycle after reset");
                end
                first = 1'b0;
            end
            if (irq) begin
                checks++;
                if (l2_addr !== exp_laddr) begin
                    errors++;
                    $display("Mismatch l2_addr: got %h expected %h", l2_addr, exp_laddr);
                end
                if (miss_stall !== 1'b1) begin
                    errors++;
                    $display("Mismatch miss_stall: got %h expected %h", miss_stall, 1'b1);
                end
                if (!saw_irq && !stall_d) begin
                    errors++;
                    $display("irq raised without miss_stall in the miss cycle at %h", if_addr);
                end
                if (data_rdy && !l2_rdy) begin
                    errors++;
                    $display("data_rdy during a miss without l2_rdy");
                end
            end
            if (data_rdy) begin
                hit = 1'b0;
                way = 1'b0;
                for (int w = 0; w < 2; w++) begin
                    if (!hit && mv[w][if_addr.index] && mt[w][if_addr.index] == if_addr.tag) begin
                        hit = 1'b1;
                        way = way_sel_t'(w);
                    end
                end
                if (!fetch_en) begin
                    errors++;
                    $display("data_rdy without a fetch at %h", if_addr);
                end
                checks++;
                if (hit == (saw_irq || irq)) begin
                    errors++;
                    $display("fetch at %h: cache %s but model predicts a %s", if_addr,
                             hit ? "missed" : "hit", hit ? "hit" : "miss");
                end
                if (hit && miss_stall) begin
                    errors++;
                    $display("miss_stall raised on a hit at %h", if_addr);
                end
                exp_word = l2_word(exp_laddr, if_addr.offset);
                checks++;
                if (cpu_data !== exp_word) begin
                    errors++;
                    $display("Mismatch cpu_data: got %h expected %h (addr %h)",
                             cpu_data, exp_word, if_addr);
                end
                if (!hit) begin  // empty way first and the lru way otherwise
                    way = !mv[0][if_addr.index] ? 1'b0 :
                          !mv[1][if_addr.index] ? 1'b1 : mlru[if_addr.index];
                    mv[way][if_addr.index] = 1'b1;
                    mt[way][if_addr.index] = if_addr.tag;
                end
                mlru[if_addr.index] = ~way;
                saw_irq = 1'b0;
            end else if (irq) begin
                saw_irq = 1'b1;
            end
            stall_d = miss_stall;
        end
    end

endmodule

// ==== tb/icache_sva.sv ====
//************************************************
// assertions on the cache controller
// bound into every icache_ctrl instance
//************************************************

`timescale 1ns/1ns

module icache_sva
    import icache_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input ic_state_t state,
    input logic      irq,
    input logic      l2_rdy,
    input logic      data_rdy,
    input way_wr_t   way0_wr,
    input way_wr_t   way1_wr
);

    // request stays up until the line arrives
    irq_until_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        irq && !l2_rdy |=> irq)
        else $error("irq dropped before l2_rdy");

    one_way_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(way0_wr.en && way1_wr.en))
        else $error("both ways written in one cycle");

    no_write_on_hit: assert property (@(posedge clk) disable iff (!rst_n)
        !(state == access && data_rdy && (way0_wr.en || way1_wr.en)))
        else $error("way written together with a hit");

endmodule

bind icache_ctrl icache_sva sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .state    (state),
    .irq      (irq),
    .l2_rdy   (l2_rdy),
    .data_rdy (data_rdy),
    .way0_wr  (way0_wr),
    .way1_wr  (way1_wr)
);

// ==== design/icache_top.sv ====
//************************************************
// two-way set-associative instruction cache
// fetch side in front, l2 request/fill port behind
// controller plus tag, data and lru stores
//************************************************

`timescale 1ns/1ns

module icache_top
    import icache_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   fetch_en,
    input  ic_addr_t               if_addr,
    output logic [word_w-1:0]      cpu_data,
    output logic                   data_rdy,
    output logic                   miss_stall,
    input  logic                   ic_en,
    input  logic                   l2_rdy,
    input  line_t                  l2_line,
    output logic                   irq,
    output logic [line_addr_w-1:0] l2_addr
);

    logic [index_w-1:0] index;
    tag_entry_t         tag0_rd;
    tag_entry_t         tag1_rd;
    line_t              line0_rd;
    line_t              line1_rd;
    way_sel_t           lru;
    way_wr_t            way0_wr;
    way_wr_t            way1_wr;
    logic               lru_touch;
    way_sel_t           lru_way;

    icache_ctrl ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_en   (fetch_en),
        .if_addr    (if_addr),
        .cpu_data   (cpu_data),
        .data_rdy   (data_rdy),
        .miss_stall (miss_stall),
        .index      (index),
        .tag0_rd    (tag0_rd),
        .tag1_rd    (tag1_rd),
        .line0_rd   (line0_rd),
        .line1_rd   (line1_rd),
        .lru        (lru),
        .way0_wr    (way0_wr),
        .way1_wr    (way1_wr),
        .lru_touch  (lru_touch),
        .lru_way    (lru_way),
        .ic_en      (ic_en),
        .l2_rdy     (l2_rdy),
        .l2_line    (l2_line),
        .irq        (irq),
        .l2_addr    (l2_addr)
    );

    icache_way_store #(.payload_t(tag_entry_t)) tag0 (
        .clk(clk), .rst_n(rst_n), .index(index),
        .wr_en(way0_wr.en), .wr_data(way0_wr.entry), .rd_data(tag0_rd)
    );

    icache_way_store #(.payload_t(tag_entry_t)) tag1 (
        .clk(clk), .rst_n(rst_n), .index(index),
        .wr_en(way1_wr.en), .wr_data(way1_wr.entry), .rd_data(tag1_rd)
    );

    icache_way_store #(.payload_t(line_t)) data0 (
        .clk(clk), .rst_n(rst_n), .index(index),
        .wr_en(way0_wr.en), .wr_data(way0_wr.line), .rd_data(line0_rd)
    );

    icache_way_store #(.payload_t(line_t)) data1 (
        .clk(clk), .rst_n(rst_n), .index(index),
        .wr_en(way1_wr.en), .wr_data(way1_wr.line), .rd_data(line1_rd)
    );

    icache_lru lru_store (
        .clk       (clk),
        .rst_n     (rst_n),
        .index     (index),
        .touch     (lru_touch),
        .touch_way (lru_way),
        .lru       (lru)
    );

endmodule

// ==== design/icache_ctrl.sv ====
//************************************************
// instruction cache controller
// tag compare, word select and the miss/refill FSM
// drives the tag, data and lru stores of both ways
//************************************************

`timescale 1ns/1ns

module icache_ctrl
    import icache_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   fetch_en,
    input  ic_addr_t               if_addr,
    output logic [word_w-1:0]      cpu_data,
    output logic                   data_rdy,
    output logic                   miss_stall,
    output logic [index_w-1:0]     index,
    input  tag_entry_t             tag0_rd,
    input  tag_entry_t             tag1_rd,
    input  line_t                  line0_rd,
    input  line_t                  line1_rd,
    input  way_sel_t               lru,
    output way_wr_t                way0_wr,
    output way_wr_t                way1_wr,
    output logic                   lru_touch,
    output way_sel_t               lru_way,
    input  logic                   ic_en,
    input  logic                   l2_rdy,
    input  line_t                  l2_line,
    output logic                   irq,
    output logic [line_addr_w-1:0] l2_addr
);

    ic_state_t state;
    ic_state_t next_state;
    logic      hit0;
    logic      hit1;
    logic      hit;
    logic      lookup;   // valid fetch seen this cycle
    logic      refill;   // l2 line arrives this cycle
    way_sel_t  hit_way;
    way_sel_t  victim;
    line_t     src_line;
    way_wr_t   fill_wr;

    assign index   = if_addr.index;
    assign l2_addr = {if_addr.tag, if_addr.index};

    assign hit0    = tag0_rd.valid && (tag0_rd.tag == if_addr.tag);
    assign hit1    = tag1_rd.valid && (tag1_rd.tag == if_addr.tag);
    assign hit     = hit0 || hit1;
    assign hit_way = hit0 ? 1'b0 : 1'b1;

    assign lookup = (state == access) && fetch_en;
    assign refill = (state == req_l2) && l2_rdy;

    // empty ways first, then the lru way
    always_comb begin
        if (!tag0_rd.valid) begin
            victim = 1'b0;
        end else if (!tag1_rd.valid) begin
            victim = 1'b1;
        end else begin
            victim = lru;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            access: begin
                if (lookup && !hit) begin
                    next_state = req_l2;
                end
            end
            req_l2: begin
                if (l2_rdy) begin
                    next_state = fill;
                end else if (!ic_en) begin
                    next_state = wait_l2;  // grant dropped so irq stays up
                end
            end
            wait_l2: begin
                if (ic_en) begin
                    next_state = req_l2;
                end
            end
            fill: begin
                next_state = access;
            end
            default: begin
                next_state = access;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= access;
        end else begin
            state <= next_state;
        end
    end

    assign irq        = (state == req_l2) || (state == wait_l2);
    assign miss_stall = (lookup && !hit) || irq;
    assign data_rdy   = (lookup && hit) || refill;

    // hit line on lookup, l2 line while refilling
    assign src_line = (state == access) ? (hit0 ? line0_rd : line1_rd) : l2_line;
    assign cpu_data = src_line[if_addr.offset];

    always_comb begin
        fill_wr             = '0;
        fill_wr.index       = if_addr.index;
        fill_wr.entry.valid = 1'b1;
        fill_wr.entry.tag   = if_addr.tag;
        fill_wr.line        = l2_line;

        way0_wr    = fill_wr;
        way0_wr.en = refill && (victim == 1'b0);
        way1_wr    = fill_wr;
        way1_wr.en = refill && (victim == 1'b1);
    end

    assign lru_touch = data_rdy;
    assign lru_way   = refill ? victim : hit_way;

endmodule

// ==== design/icache_lru.sv ====
//************************************************
// per-set replacement bit for the two-way cache
// bit names the least recently used way
// touch flips it away from the way just used
//************************************************

`timescale 1ns/1ns

module icache_lru
    import icache_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [index_w-1:0] index,
    input  logic               touch,
    input  way_sel_t           touch_way,
    output way_sel_t           lru
);

    logic [sets-1:0] lru_bits;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lru_bits <= '0;
        end else if (touch) begin
            lru_bits[index] <= ~touch_way;  // other way is now oldest
        end
    end

    assign lru = lru_bits[index];

endmodule

// ==== design/icache_way_store.sv ====
//************************************************
// one cache way, one entry per set
// read is combinational, write lands on the clock edge
// payload_t picks tag entries or data lines
//************************************************

`timescale 1ns/1ns

module icache_way_store
    import icache_pkg::*;
#(
    parameter type payload_t = logic
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [index_w-1:0] index,
    input  logic               wr_en,
    input  payload_t           wr_data,
    output payload_t           rd_data
);

    payload_t mem [sets];

    // reset zero also clears tag valid bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < sets; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[index] <= wr_data;
        end
    end

    assign rd_data = mem[index];  // same-cycle lookup

endmodule

// ==== design/icache_pkg.sv ====
//************************************************
// shared types for the two-way instruction cache
// import with icache_pkg::* in the module header
// covers address split, store payloads and FSM states
//************************************************

package icache_pkg;

    localparam int addr_w         = 30;   // word address
    localparam int index_w        = 8;
    localparam int sets           = 256;
    localparam int tag_w          = 20;
    localparam int words_per_line = 4;
    localparam int line_w         = 128;
    localparam int word_w         = line_w / words_per_line;
    localparam int offset_w       = $clog2(words_per_line);
    localparam int line_addr_w    = addr_w - offset_w;  // l2 line address

    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [index_w-1:0]  index;
        logic [offset_w-1:0] offset;
    } ic_addr_t;

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
    } tag_entry_t;

    // word 0 sits in the low bits
    typedef logic [words_per_line-1:0][word_w-1:0] line_t;

    typedef logic way_sel_t;

    typedef enum logic [1:0] {
        access,
        req_l2,
        wait_l2,
        fill
    } ic_state_t;

    typedef struct packed {
        logic               en;
        logic [index_w-1:0] index;
        tag_entry_t         entry;
        line_t              line;
    } way_wr_t;

endpackage
